// File: rtl/data_ram.sv
`timescale 1ns/1ps
`include "rv64_defs.svh"

module data_ram (
    input  logic clk,
    dmem_if.ram  dmem
);

    logic [`XLEN-1:0] mem [`RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (dmem.en) begin
            if (dmem.we) begin
                for (int i = 0; i < `XBYTES; i++) begin
                    if (dmem.wstrb[i]) begin
                        mem[dmem.addr][i*8 +: 8] <= dmem.wdata[i*8 +: 8];
                    end
                end
            end else begin
                dmem.rdata <= mem[dmem.addr]; // read holds until next read
            end
        end
    end

    a_we_needs_en: assert property (@(posedge clk)
        dmem.we |-> dmem.en);

endmodule

// File: rtl/dmem_if.sv
`timescale 1ns/1ps
`include "rv64_defs.svh"

interface dmem_if;

    logic                en;     // access this cycle
    logic                we;     // store, qualified by en
    logic [`RAM_AW-1:0]  addr;   // doubleword address
    logic [`XBYTES-1:0]  wstrb;
    logic [`XLEN-1:0]    wdata;
    logic [`XLEN-1:0]    rdata;  // valid one cycle after a read

    modport cpu (
        output en, we, addr, wstrb, wdata,
        input  rdata
    );

    modport ram (
        input  en, we, addr, wstrb, wdata,
        output rdata
    );

endinterface

// File: rtl/mem_stage.sv
`timescale 1ns/1ps
`include "rv64_defs.svh"

module mem_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      es_to_ms_valid,
    output logic                      ms_allowin,
    input  logic                      es_reg_wen,
    input  logic [`REG_AW-1:0]        es_rd,
    input  wb_types_pkg::wreg_sel_e   es_wreg_sel,
    input  mem_types_pkg::mem_op_e    es_mem_op,
    input  logic [`XLEN-1:0]          es_alu_result,
    input  logic [`XLEN-1:0]          es_store_data,
    input  logic [`XLEN-1:0]          es_pc,
    dmem_if.cpu                       dmem,
    ms_ws_if.ms                       ws
);
    import mem_types_pkg::*;
    import wb_types_pkg::*;

    logic               ms_valid;
    logic               ms_ready_go;
    logic               accept;
    logic               es_is_load;
    logic               es_is_store;
    logic               es_ld_req;
    logic [2:0]         st_lane;     // byte lane of the store
    logic [`XBYTES-1:0] st_strb;

    logic               ms_reg_wen;
    logic [`REG_AW-1:0] ms_rd;
    wreg_sel_e          ms_wreg_sel;
    mem_op_e            ms_mem_op;
    logic [`XLEN-1:0]   ms_alu_result;
    logic [`XLEN-1:0]   ms_pc;
    logic [2:0]         ms_off;
    load_word_u         ld_word;
    logic [7:0]         ld_byte;
    logic [15:0]        ld_half;
    logic [31:0]        ld_wrd;

    assign ms_ready_go = 1'b1;
    assign ms_allowin  = !ms_valid || (ms_ready_go && ws.allowin);
    assign accept      = es_to_ms_valid && ms_allowin;

    assign es_is_load  = es_mem_op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LD,
                                           MEM_LBU, MEM_LHU, MEM_LWU};
    assign es_is_store = es_mem_op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD};
    assign es_ld_req   = accept && es_is_load;

    always_comb begin
        st_lane = 3'd0;
        st_strb = '0;
        case (es_mem_op)
            MEM_SB: begin
                st_lane = es_alu_result[2:0];
                st_strb = 8'h01 << st_lane;
            end
            MEM_SH: begin
                st_lane = {es_alu_result[2:1], 1'b0};
                st_strb = 8'h03 << st_lane;
            end
            MEM_SW: begin
                st_lane = {es_alu_result[2], 2'b00};
                st_strb = 8'h0f << st_lane;
            end
            MEM_SD:  st_strb = 8'hff;
            default: ;
        endcase
    end

    // RAM request is made in the accept cycle
    assign dmem.en    = accept && (es_is_load || es_is_store);
    assign dmem.we    = accept && es_is_store;
    assign dmem.addr  = es_alu_result[`RAM_AW+2:3];
    assign dmem.wstrb = st_strb;
    assign dmem.wdata = es_store_data << {st_lane, 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
        if (accept) begin
            ms_reg_wen    <= es_reg_wen;
            ms_rd         <= es_rd;
            ms_wreg_sel   <= es_wreg_sel;
            ms_mem_op     <= es_mem_op;
            ms_alu_result <= es_alu_result;
            ms_pc         <= es_pc;
            ms_off        <= es_alu_result[2:0];
        end
    end

    // pick the addressed field out of the returned word
    assign ld_word = dmem.rdata;
    assign ld_byte = ld_word.b[ms_off];
    assign ld_half = ld_word.h[ms_off[2:1]];
    assign ld_wrd  = ld_word.w[ms_off[2]];

    always_comb begin
        case (ms_mem_op)
            MEM_LB:  ws.load_data = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
            MEM_LH:  ws.load_data = {{(`XLEN-16){ld_half[15]}}, ld_half};
            MEM_LW:  ws.load_data = {{(`XLEN-32){ld_wrd[31]}}, ld_wrd};
            MEM_LD:  ws.load_data = ld_word.dword;
            MEM_LBU: ws.load_data = {{(`XLEN-8){1'b0}}, ld_byte};
            MEM_LHU: ws.load_data = {{(`XLEN-16){1'b0}}, ld_half};
            MEM_LWU: ws.load_data = {{(`XLEN-32){1'b0}}, ld_wrd};
            default: ws.load_data = '0;
        endcase
    end

    assign ws.valid      = ms_valid && ms_ready_go;
    assign ws.reg_wen    = ms_reg_wen;
    assign ws.rd         = ms_rd;
    assign ws.wreg_sel   = ms_wreg_sel;
    assign ws.alu_result = ms_alu_result;
    assign ws.pc         = ms_pc;

    // a load request carries no store strobes
    a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
        !(es_ld_req && dmem.wstrb != '0));

endmodule

// File: rtl/mem_types_pkg.sv
`include "rv64_defs.svh"

package mem_types_pkg;

    // memory operation carried with each instruction
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LD   = 4'd4,
        MEM_LBU  = 4'd5,
        MEM_LHU  = 4'd6,
        MEM_LWU  = 4'd7,
        MEM_SB   = 4'd8,
        MEM_SH   = 4'd9,
        MEM_SW   = 4'd10,
        MEM_SD   = 4'd11
    } mem_op_e;

    // one RAM word seen at each access size, index is the lane
    typedef union packed {
        logic [`XLEN-1:0]                 dword;
        logic [`XBYTES-1:0][7:0]          b;
        logic [`XLEN/16-1:0][15:0]        h;
        logic [`XLEN/32-1:0][31:0]        w;
    } load_word_u;

endpackage

// File: rtl/ms_ws_if.sv
`timescale 1ns/1ps
`include "rv64_defs.svh"

interface ms_ws_if;
    import wb_types_pkg::*;

    logic              valid;
    logic              allowin;
    logic              reg_wen;
    logic [`REG_AW-1:0] rd;
    wreg_sel_e         wreg_sel;
    logic [`XLEN-1:0]  load_data;  // already extended
    logic [`XLEN-1:0]  alu_result;
    logic [`XLEN-1:0]  pc;

    modport ms (
        output valid, reg_wen, rd, wreg_sel, load_data, alu_result, pc,
        input  allowin
    );

    modport ws (
        input  valid, reg_wen, rd, wreg_sel, load_data, alu_result, pc,
        output allowin
    );

endinterface

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "rv64_defs.svh"

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               rf_wen,
    input  logic [`REG_AW-1:0] rf_waddr,
    input  logic [`XLEN-1:0]   rf_wdata,
    input  logic [`REG_AW-1:0] raddr1,
    output logic [`XLEN-1:0]   rdata1,
    input  logic [`REG_AW-1:0] raddr2,
    output logic [`XLEN-1:0]   rdata2
);

    // x0 is cleared by reset and never written
    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wen && rf_waddr != '0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // x0 reads zero on both ports
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0));

    // a write shows on port 1 right after the edge
    a_wr_visible: assert property (@(posedge clk) disable iff (rst)
        (rf_wen && rf_waddr != '0) ##1 (raddr1 == $past(rf_waddr))
            |-> (rdata1 == $past(rf_wdata)));

endmodule

// File: rtl/rv64_backend.sv
`timescale 1ns/1ps
`include "rv64_defs.svh"

module rv64_backend (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      es_to_ms_valid,
    output logic                      ms_allowin,
    input  logic                      es_reg_wen,
    input  logic [`REG_AW-1:0]        es_rd,
    input  wb_types_pkg::wreg_sel_e   es_wreg_sel,
    input  mem_types_pkg::mem_op_e    es_mem_op,
    input  logic [`XLEN-1:0]          es_alu_result,
    input  logic [`XLEN-1:0]          es_store_data,
    input  logic [`XLEN-1:0]          es_pc,
    input  logic [`REG_AW-1:0]        rf_raddr1,
    output logic [`XLEN-1:0]          rf_rdata1,
    input  logic [`REG_AW-1:0]        rf_raddr2,
    output logic [`XLEN-1:0]          rf_rdata2
);

    logic               rf_wen;
    logic [`REG_AW-1:0] rf_waddr;
    logic [`XLEN-1:0]   rf_wdata;

    ms_ws_if i_ms_ws ();
    dmem_if  i_dmem ();

    mem_stage i_mem_stage (
        .clk            (clk),
        .rst            (rst),
        .es_to_ms_valid (es_to_ms_valid),
        .ms_allowin     (ms_allowin),
        .es_reg_wen     (es_reg_wen),
        .es_rd          (es_rd),
        .es_wreg_sel    (es_wreg_sel),
        .es_mem_op      (es_mem_op),
        .es_alu_result  (es_alu_result),
        .es_store_data  (es_store_data),
        .es_pc          (es_pc),
        .dmem           (i_dmem.cpu),
        .ws             (i_ms_ws.ms)
    );

    data_ram i_data_ram (
        .clk  (clk),
        .dmem (i_dmem.ram)
    );

    wb_stage i_wb_stage (
        .clk      (clk),
        .rst      (rst),
        .ms       (i_ms_ws.ws),
        .rf_wen   (rf_wen),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

    // read ports go out to decode
    regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .rf_wen   (rf_wen),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .raddr1   (rf_raddr1),
        .rdata1   (rf_rdata1),
        .raddr2   (rf_raddr2),
        .rdata2   (rf_rdata2)
    );

endmodule

// File: rtl/rv64_defs.svh
`ifndef RV64_DEFS_SVH
`define RV64_DEFS_SVH

// datapath width
`define XLEN 64

// bytes per data word, one strobe bit each
`define XBYTES (`XLEN / 8)

// register file address width, 32 registers
`define REG_AW 5

// data RAM word address width
`define RAM_AW 9

// doublewords in the data RAM
`define RAM_DEPTH (1 << `RAM_AW)

`endif

// File: rtl/wb_stage.sv
`timescale 1ns/1ps
`include "rv64_defs.svh"

module wb_stage (
    input  logic               clk,
    input  logic               rst,
    ms_ws_if.ws                ms,
    output logic               rf_wen,
    output logic [`REG_AW-1:0] rf_waddr,
    output logic [`XLEN-1:0]   rf_wdata
);
    import wb_types_pkg::*;

    logic               ws_valid;
    logic               ws_ready_go;
    logic               ws_allowin;

    logic               ws_reg_wen;
    logic [`REG_AW-1:0] ws_rd;
    wreg_sel_e          ws_wreg_sel;
    logic [`XLEN-1:0]   ws_load_data;
    logic [`XLEN-1:0]   ws_alu_result;
    logic [`XLEN-1:0]   ws_pc;

    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go; // last stage, nothing downstream
    assign ms.allowin  = ws_allowin;

    always_ff @(posedge clk) begin
        if (rst) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms.valid;
        end
        if (ms.valid && ws_allowin) begin
            ws_reg_wen    <= ms.reg_wen;
            ws_rd         <= ms.rd;
            ws_wreg_sel   <= ms.wreg_sel;
            ws_load_data  <= ms.load_data;
            ws_alu_result <= ms.alu_result;
            ws_pc         <= ms.pc;
        end
    end

    assign rf_wen   = ws_reg_wen && ws_valid;
    assign rf_waddr = ws_rd;

    always_comb begin
        case (ws_wreg_sel)
            WREG_ALU: rf_wdata = ws_alu_result;
            WREG_RAM: rf_wdata = ws_load_data;
            WREG_PC:  rf_wdata = ws_pc;       // jal/jalr link
            default:  rf_wdata = '0;
        endcase
    end

    a_sel_legal: assert property (@(posedge clk) disable iff (rst)
        ws_valid |-> (ws_wreg_sel inside {WREG_ALU, WREG_RAM, WREG_PC}));

endmodule

// File: rtl/wb_types_pkg.sv
package wb_types_pkg;

    // source of the value written back to rd
    typedef enum logic [1:0] {
        WREG_ALU = 2'd0, // arithmetic result
        WREG_RAM = 2'd1, // aligned load data
        WREG_PC  = 2'd2  // link address for jal/jalr
    } wreg_sel_e;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
    -f rv64_backend.f \
    --top-module tb_rv64_backend \
    --Mdir build -o tb_rv64_backend

./build/tb_rv64_backend | tee build/sim.log

if grep -qx "All checks passed" build/sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: rv64_backend.f
+incdir+rtl
rtl/wb_types_pkg.sv
rtl/mem_types_pkg.sv
rtl/ms_ws_if.sv
rtl/dmem_if.sv
rtl/mem_stage.sv
rtl/data_ram.sv
rtl/wb_stage.sv
rtl/regfile.sv
rtl/rv64_backend.sv
sim/tb_rv64_backend.sv

// File: sim/tb_rv64_backend.sv
`timescale 1ns/1ps
`include "rv64_defs.svh"

module tb_rv64_backend;
    import wb_types_pkg::*;
    import mem_types_pkg::*;

    typedef struct {
        int                 test;
        logic               valid;
        logic               reg_wen;
        logic [`REG_AW-1:0] rd;
        wreg_sel_e          sel;
        mem_op_e            op;
        logic [`XLEN-1:0]   alu;
        logic [`XLEN-1:0]   sdata;
        logic [`XLEN-1:0]   pc;
        logic               chk;   // read rd back after writeback
        logic [`XLEN-1:0]   exp;
    } row_t;

    logic               clk = 1'b0;
    logic               rst, es_to_ms_valid, ms_allowin, es_reg_wen;
    logic [`REG_AW-1:0] es_rd, rf_raddr1, rf_raddr2;
    wreg_sel_e          es_wreg_sel;
    mem_op_e            es_mem_op;
    logic [`XLEN-1:0]   es_alu_result, es_store_data, es_pc, rf_rdata1, rf_rdata2;

    row_t               rows [$];
    row_t               idle;
    logic [7:0]         shadow_mem [`RAM_DEPTH*8]; // byte image of the RAM
    logic [`XLEN-1:0]   shadow_reg [32];
    integer             seed;
    bit                 table_ready;
    int                 cur_test;
    int                 test_chk [6];
    int                 test_err [6];

    always #5 clk = ~clk;

    rv64_backend i_rv64_backend (.*);

    task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        test_chk[cur_test]++;
        if (got !== exp) begin
            test_err[cur_test]++;
            $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic int access_bytes(input mem_op_e op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return 1;
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            MEM_LW, MEM_LWU, MEM_SW: return 4;
            default:                 return 8;
        endcase
    endfunction

    // little endian gather, then RISC-V sign or zero extension
    function automatic logic [`XLEN-1:0] load_expect(input mem_op_e op,
                                                     input logic [`RAM_AW+2:0] a);
        logic [`XLEN-1:0]   raw;
        logic [`RAM_AW+2:0] ba;
        raw = '0;
        for (int i = 0; i < access_bytes(op); i++) begin
            ba = a + i[`RAM_AW+2:0];
            raw[i*8 +: 8] = shadow_mem[ba];
        end
        case (op)
            MEM_LB:  return {{(`XLEN-8){raw[7]}}, raw[7:0]};
            MEM_LH:  return {{(`XLEN-16){raw[15]}}, raw[15:0]};
            MEM_LW:  return {{(`XLEN-32){raw[31]}}, raw[31:0]};
            default: return raw; // LD and the unsigned loads
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic add_row(input int t, input logic valid, input logic wen,
                           input logic [`REG_AW-1:0] rd, input wreg_sel_e sel,
                           input mem_op_e op, input logic [`XLEN-1:0] alu,
                           input logic [`XLEN-1:0] sdata, input logic [`XLEN-1:0] pc);
        row_t               r;
        logic               st;
        logic [`RAM_AW+2:0] ba;
        st = op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD};
        r = '{t, valid, wen, rd, sel, op, alu, sdata, pc, !st, '0};
        if (valid && st) begin
            for (int i = 0; i < access_bytes(op); i++) begin
                ba = alu[`RAM_AW+2:0] + i[`RAM_AW+2:0];
                shadow_mem[ba] = sdata[i*8 +: 8];
            end
        end
        if (valid && wen && rd != '0) begin
            case (sel)
                WREG_PC:  shadow_reg[rd] = pc;
                WREG_RAM: shadow_reg[rd] = load_expect(op, alu[`RAM_AW+2:0]);
                default:  shadow_reg[rd] = alu;
            endcase
        end
        r.exp = shadow_reg[rd]; // x0 entry stays zero
        rows.push_back(r);
    endtask

    task automatic build_table();
        foreach (shadow_reg[i]) begin
            shadow_reg[i] = '0;
        end
        idle = '{0, 1'b0, 1'b0, '0, WREG_ALU, MEM_NONE, '0, '0, '0, 1'b0, '0};
        // test valid wen rd sel op alu_result store_data pc
        add_row(1, 1, 1, 1, WREG_ALU, MEM_NONE, 64'h0123_4567_89ab_cdef, '0, 64'h1000);
        add_row(1, 1, 1, 2, WREG_ALU, MEM_NONE, 64'hffff_ffff_ffff_fffe, '0, 64'h1004);
        add_row(1, 1, 1, 31, WREG_ALU, MEM_NONE, rand64(), '0, 64'h1008);
        add_row(2, 1, 1, 10, WREG_PC, MEM_NONE, rand64(), '0, 64'h8000_0010);
        add_row(2, 1, 1, 11, WREG_PC, MEM_NONE, '0, '0, 64'hffff_ffff_8000_1ffc);
        add_row(3, 1, 0, 0, WREG_ALU, MEM_SD, 64'h100, rand64(), '0);
        add_row(3, 1, 0, 0, WREG_ALU, MEM_SW, 64'h108, rand64(), '0);
        add_row(3, 1, 0, 0, WREG_ALU, MEM_SW, 64'h10c, rand64(), '0);
        add_row(3, 1, 0, 0, WREG_ALU, MEM_SH, 64'h116, 64'h7ff1, '0);
        add_row(3, 1, 0, 0, WREG_ALU, MEM_SB, 64'h119, rand64(), '0);
        add_row(3, 1, 0, 0, WREG_ALU, MEM_SB, 64'h11a, 64'h80, '0); // negative byte
        add_row(3, 1, 1, 5, WREG_RAM, MEM_LD, 64'h100, '0, '0);
        add_row(3, 1, 1, 6, WREG_RAM, MEM_LW, 64'h104, '0, '0);
        add_row(3, 1, 1, 7, WREG_RAM, MEM_LWU, 64'h10c, '0, '0);
        add_row(3, 1, 1, 8, WREG_RAM, MEM_LW, 64'h108, '0, '0);
        add_row(3, 1, 1, 9, WREG_RAM, MEM_LH, 64'h116, '0, '0);
        add_row(3, 1, 1, 12, WREG_RAM, MEM_LHU, 64'h102, '0, '0);
        add_row(3, 1, 1, 13, WREG_RAM, MEM_LB, 64'h11a, '0, '0);
        add_row(3, 1, 1, 14, WREG_RAM, MEM_LBU, 64'h11a, '0, '0);
        add_row(3, 1, 1, 15, WREG_RAM, MEM_LB, 64'h119, '0, '0);
        add_row(4, 1, 1, 0, WREG_ALU, MEM_NONE, 64'h5a5a, '0, '0);
        add_row(4, 1, 1, 0, WREG_RAM, MEM_LD, 64'h100, '0, '0);
        add_row(4, 1, 1, 0, WREG_PC, MEM_NONE, '0, '0, 64'h2000);
        add_row(4, 1, 0, 1, WREG_ALU, MEM_NONE, 64'h1111, '0, '0);  // wen low
        add_row(4, 0, 1, 2, WREG_ALU, MEM_NONE, 64'h2222, '0, '0);  // bubble
        add_row(5, 1, 1, 20, WREG_ALU, MEM_NONE, rand64(), '0, '0);
        add_row(5, 1, 1, 20, WREG_ALU, MEM_NONE, rand64(), '0, '0); // same rd in order
        add_row(5, 1, 0, 0, WREG_ALU, MEM_SD, 64'h1f8, rand64(), '0);
        add_row(5, 1, 1, 21, WREG_RAM, MEM_LD, 64'h1f8, '0, '0);    // right behind the store
        add_row(5, 1, 1, 22, WREG_PC, MEM_NONE, '0, '0, 64'h4000_0040);
        add_row(5, 1, 1, 23, WREG_RAM, MEM_LWU, 64'h1fc, '0, '0);
        add_row(5, 1, 1, 24, WREG_RAM, MEM_LBU, 64'h1ff, '0, '0);
    endtask

    task automatic drive_row(input row_t r);
        es_to_ms_valid = r.valid;
        es_reg_wen     = r.reg_wen;
        es_rd          = r.rd;
        es_wreg_sel    = r.sel;
        es_mem_op      = r.op;
        es_alu_result  = r.alu;
        es_store_data  = r.sdata;
        es_pc          = r.pc;
    endtask

    // one row per cycle, rd read back in the cycle after its write edge
    task automatic run_test(input int t, input string title);
        int idx [$];
        int j;
        foreach (rows[i]) begin
            if (rows[i].test == t) begin
                idx.push_back(i);
            end
        end
        cur_test = t;
        rf_raddr2 = '0;
        for (int n = 0; n < idx.size() + 3; n++) begin
            @(posedge clk);
            #1;
            drive_row((n < idx.size()) ? rows[idx[n]] : idle);
            j = n - 3;
            if (j >= 0) begin
                rf_raddr1 = rows[idx[j]].rd;
                if (t != 4) begin
                    rf_raddr2 = rows[idx[j]].rd; // second read port on the same rd
                end
            end
            @(negedge clk);
            if (n < idx.size()) begin
                check_value("ms_allowin", 64'(ms_allowin), 64'd1);
            end
            if (t == 4) begin
                check_value("rf_rdata2", rf_rdata2, '0); // port 2 parked on x0
            end
            if (j >= 0 && rows[idx[j]].chk) begin
                check_value($sformatf("x%0d", rows[idx[j]].rd), rf_rdata1, rows[idx[j]].exp);
                if (t != 4) begin
                    check_value($sformatf("x%0d port 2", rows[idx[j]].rd), rf_rdata2,
                                rows[idx[j]].exp);
                end
            end
        end
        $display("test %0d %s: %0d checks, %0d errors", t, title, test_chk[t], test_err[t]);
    endtask

    initial begin
        int total_chk;
        int total_err;
        seed = 3;
        rst = 1'b1;
        rf_raddr1 = 5'd5;
        rf_raddr2 = '0;
        build_table();
        table_ready = 1'b1;
        cur_test = 5;
        // request held through reset, x5 must stay clear
        drive_row('{5, 1'b1, 1'b1, 5'd5, WREG_ALU, MEM_NONE, 64'hdead_beef, '0, '0, 1'b0, '0});
        repeat (2) begin
            @(posedge clk);
            #1;
            check_value("ms_allowin", 64'(ms_allowin), 64'd1);
        end
        rst = 1'b0;
        drive_row(idle);
        repeat (3) @(posedge clk);
        #1;
        check_value("x5", rf_rdata1, '0);
        run_test(1, "alu writeback");
        run_test(2, "link writeback");
        run_test(3, "store then load");
        run_test(4, "x0 and write enable");
        run_test(5, "back-to-back");
        total_chk = 0;
        total_err = 0;
        for (int t = 1; t <= 5; t++) begin
            total_chk += test_chk[t];
            total_err += test_err[t];
        end
        $display("done: %0d checks, %0d errors", total_chk, total_err);
        if (total_err == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // generous bound, about ten cycles per table row
    initial begin
        int limit;
        wait (table_ready);
        limit = rows.size() * 10 + 100;
        repeat (limit) @(posedge clk);
        $display("timeout: the tests were still running after %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule
